// File: hdl/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Fetch PC after reset and per-instruction advance
`define RESET_PC 32'h0000_0000
`define PC_STEP 32'd4

// Management address regions, bits 15:14
`define MGMT_REGION_SYSTEM 2'b00
`define MGMT_REGION_REGISTERS 2'b01

// Word selects in the system region, bits 13:4
`define MGMT_SYS_PC 10'h000
`define MGMT_SYS_INSTR 10'h001

// Offsets within the PC word, bits 3:0
`define MGMT_PC_SET 4'h0
`define MGMT_PC_STEP 4'h8

// Opcodes of the supported instructions
`define OPCODE_OPIMM 7'b0010011
`define OPCODE_OP 7'b0110011
`define OPCODE_LUI 7'b0110111

`endif

// File: hdl/corePkg.sv
`default_nettype none

package corePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIndex_t;
	typedef logic [15:0] mgmtAddr_t;
	typedef logic [3:0] byteSel_t;

	typedef enum logic {
		stateHalt = 1'b0,
		stateExecute = 1'b1
	} coreState_e;

	typedef struct packed {
		word_t address;
		logic enable;
	} imemReq_t;

	typedef struct packed {
		word_t data;
		logic busy;
	} imemRsp_t;

	// Host side of the management bus
	typedef struct packed {
		logic run;
		logic writeEnable;
		byteSel_t byteSelect;
		mgmtAddr_t address;
		word_t writeData;
	} mgmtReq_t;

	typedef struct packed {
		logic valid;
		word_t instruction;
		word_t pc;
	} fetchOut_t;

	typedef struct packed {
		logic enable;
		regIndex_t index;
		word_t data;
	} writeBack_t;

endpackage

`default_nettype wire

// File: hdl/runControl.sv
`timescale 1ns/10ps
`default_nettype none

module runControl import corePkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input wire logic stepWrite,
	input wire logic pipeActive,
	input wire logic fetchBusy,
	output logic stepPipe,
	output logic allowFetch,
	output coreState_e state
);

	logic stepPending;
	logic keepRunning;

	assign allowFetch = run || stepPending;
	assign keepRunning = allowFetch || pipeActive;

	// Busy only matters while a fetch is requested
	assign stepPipe = (state == stateExecute) && !(allowFetch && fetchBusy);

	always_ff @(posedge clk) begin
		if (rst) begin
			stepPending <= 1'b0;
		end else if (stepWrite) begin
			stepPending <= 1'b1;
		end else if (stepPipe && allowFetch) begin
			stepPending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateHalt;
		end else begin
			case (state)
				stateHalt: begin
					if (keepRunning) begin
						state <= stateExecute;
					end
				end
				stateExecute: begin
					// Drained and nothing left to fetch
					if (stepPipe && !keepRunning) begin
						state <= stateHalt;
					end
				end
				default: state <= stateHalt;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/programCounter.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module programCounter import corePkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic stepPipe,
	input wire logic allowFetch,
	input wire logic setWrite,
	input wire word_t setValue,
	output word_t fetchPc
);

	logic advance;

	// A fetch was taken this cycle
	assign advance = stepPipe && allowFetch;

	always_ff @(posedge clk) begin
		if (rst) begin
			fetchPc <= `RESET_PC;
		end else if (advance) begin
			fetchPc <= fetchPc + `PC_STEP;
		end else if (setWrite) begin
			// Host writes only arrive with run low
			fetchPc <= setValue;
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetchStage.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage import corePkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic stepPipe,
	input wire logic allowFetch,
	input wire word_t fetchPc,
	input wire imemRsp_t imemRsp,
	input wire coreState_e state,
	output imemReq_t imemReq,
	output fetchOut_t fetchOut
);

	logic fetchEnable;

	assign fetchEnable = (state == stateExecute) && allowFetch;

	always_comb begin
		imemReq.address = fetchPc;
		imemReq.enable = fetchEnable;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fetchOut.valid <= 1'b0;
		end else if (stepPipe) begin
			fetchOut.valid <= fetchEnable;
		end
	end

	// Held between fetches so the host can read back the last instruction
	always_ff @(posedge clk) begin
		if (stepPipe && fetchEnable) begin
			fetchOut.instruction <= imemRsp.data;
			fetchOut.pc <= fetchPc;
		end
	end

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module executeStage import corePkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic stepPipe,
	input wire fetchOut_t fetchOut,
	input wire word_t rs1Data,
	input wire word_t rs2Data,
	output regIndex_t rs1Index,
	output regIndex_t rs2Index,
	output writeBack_t writeBack,
	output word_t executePc,
	output logic active
);

	logic [6:0] opcode;
	logic [6:0] funct7;
	logic [2:0] funct3;
	regIndex_t rd;
	word_t immediate;
	word_t upperImmediate;
	word_t operandB;
	word_t result;
	logic isOp;
	logic isSub;
	logic funct7Ok;
	logic kept;

	assign opcode = fetchOut.instruction[6:0];
	assign rd = fetchOut.instruction[11:7];
	assign funct3 = fetchOut.instruction[14:12];
	assign rs1Index = fetchOut.instruction[19:15];
	assign rs2Index = fetchOut.instruction[24:20];
	assign funct7 = fetchOut.instruction[31:25];

	assign immediate = {{20{fetchOut.instruction[31]}}, fetchOut.instruction[31:20]};
	assign upperImmediate = {fetchOut.instruction[31:12], 12'h000};

	assign isOp = (opcode == `OPCODE_OP);
	assign isSub = isOp && (funct7 == 7'b0100000) && (funct3 == 3'b000);
	// Register ops need a clean funct7 apart from SUB
	assign funct7Ok = !isOp || (funct7 == 7'b0000000) || isSub;
	assign operandB = isOp ? rs2Data : immediate;

	always_comb begin
		kept = 1'b0;
		result = '0;
		if (opcode == `OPCODE_LUI) begin
			kept = 1'b1;
			result = upperImmediate;
		end else if (isOp || opcode == `OPCODE_OPIMM) begin
			case (funct3)
				3'b000: begin
					kept = funct7Ok;
					result = isSub ? rs1Data - operandB : rs1Data + operandB;
				end
				3'b100: begin
					kept = funct7Ok;
					result = rs1Data ^ operandB;
				end
				3'b110: begin
					kept = funct7Ok;
					result = rs1Data | operandB;
				end
				3'b111: begin
					kept = funct7Ok;
					result = rs1Data & operandB;
				end
				default: kept = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			writeBack.enable <= 1'b0;
			active <= 1'b0;
			executePc <= `RESET_PC;
		end else if (stepPipe) begin
			writeBack.enable <= fetchOut.valid && kept && (rd != '0);
			active <= fetchOut.valid;
			if (fetchOut.valid) begin
				executePc <= fetchOut.pc;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stepPipe) begin
			writeBack.index <= rd;
			writeBack.data <= result;
		end
	end

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

module registerFile import corePkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic stepPipe,
	input wire writeBack_t writeBack,
	input wire regIndex_t rs1Index,
	input wire regIndex_t rs2Index,
	input wire regIndex_t mgmtIndex,
	output word_t rs1Data,
	output word_t rs2Data,
	output word_t mgmtData
);

	word_t registers [32];

	// Source read with the pending write-back forwarded
	function automatic word_t readSource(regIndex_t index);
		word_t value;
		if (index == '0) begin
			value = '0;
		end else if (writeBack.enable && writeBack.index == index) begin
			value = writeBack.data;
		end else begin
			value = registers[index];
		end
		return value;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst && stepPipe && writeBack.enable && writeBack.index != '0) begin
			registers[writeBack.index] <= writeBack.data;
		end
	end

	always_comb begin
		rs1Data = readSource(rs1Index);
		rs2Data = readSource(rs2Index);
		mgmtData = (mgmtIndex == '0) ? '0 : registers[mgmtIndex];
	end

endmodule

`default_nettype wire

// File: hdl/managementPort.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module managementPort import corePkg::*; (
	input wire mgmtReq_t mgmtReq,
	input wire word_t fetchPc,
	input wire word_t lastInstruction,
	input wire word_t mgmtData,
	output word_t readData,
	output logic stepWrite,
	output logic setWrite,
	output regIndex_t mgmtIndex
);

	logic [1:0] region;
	logic [9:0] sysWord;
	logic [3:0] offset;
	logic selectPc;
	logic selectInstr;
	logic selectRegister;
	logic writeValid;
	logic readValid;
	word_t source;

	assign region = mgmtReq.address[15:14];
	assign sysWord = mgmtReq.address[13:4];
	assign offset = mgmtReq.address[3:0];
	assign mgmtIndex = mgmtReq.address[6:2];

	assign selectPc = (region == `MGMT_REGION_SYSTEM) && (sysWord == `MGMT_SYS_PC);
	assign selectInstr = (region == `MGMT_REGION_SYSTEM) && (sysWord == `MGMT_SYS_INSTR);
	assign selectRegister = (region == `MGMT_REGION_REGISTERS) && (mgmtReq.address[13:7] == '0);

	// Host access only while the core is not running
	assign writeValid = !mgmtReq.run && mgmtReq.writeEnable;
	assign readValid = !mgmtReq.run && !mgmtReq.writeEnable;

	assign setWrite = writeValid && selectPc && (offset == `MGMT_PC_SET);
	assign stepWrite = writeValid && selectPc && (offset == `MGMT_PC_STEP);

	always_comb begin
		if (readValid && selectPc) begin
			source = fetchPc;
		end else if (readValid && selectInstr) begin
			source = lastInstruction;
		end else if (readValid && selectRegister) begin
			source = mgmtData;
		end else begin
			source = '1;
		end
	end

	always_comb begin
		for (int lane = 0; lane < 4; lane++) begin
			readData[lane*8 +: 8] = mgmtReq.byteSelect[lane] ? source[lane*8 +: 8] : 8'h00;
		end
	end

endmodule

`default_nettype wire

// File: hdl/rv32Core.sv
`timescale 1ns/10ps
`default_nettype none

module rv32Core import corePkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire imemRsp_t imemRsp,
	input wire mgmtReq_t mgmtReq,
	output imemReq_t imemReq,
	output word_t mgmtReadData,
	output logic probeState,
	output word_t probeProgramCounter
);

	logic stepPipe;
	logic allowFetch;
	logic stepWrite;
	logic setWrite;
	logic executeActive;
	logic pipeActive;
	coreState_e state;
	word_t fetchPc;
	word_t rs1Data;
	word_t rs2Data;
	word_t mgmtData;
	regIndex_t rs1Index;
	regIndex_t rs2Index;
	regIndex_t mgmtIndex;
	fetchOut_t fetchOut;
	writeBack_t writeBack;

	assign pipeActive = fetchOut.valid || executeActive;
	assign probeState = (state == stateExecute);

	runControl u_runControl (
		.clk(clk),
		.rst(rst),
		.run(mgmtReq.run),
		.stepWrite(stepWrite),
		.pipeActive(pipeActive),
		.fetchBusy(imemRsp.busy),
		.stepPipe(stepPipe),
		.allowFetch(allowFetch),
		.state(state)
	);

	programCounter u_programCounter (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.allowFetch(allowFetch),
		.setWrite(setWrite),
		.setValue(mgmtReq.writeData),
		.fetchPc(fetchPc)
	);

	fetchStage u_fetchStage (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.allowFetch(allowFetch),
		.fetchPc(fetchPc),
		.imemRsp(imemRsp),
		.state(state),
		.imemReq(imemReq),
		.fetchOut(fetchOut)
	);

	executeStage u_executeStage (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.fetchOut(fetchOut),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.writeBack(writeBack),
		.executePc(probeProgramCounter),
		.active(executeActive)
	);

	registerFile u_registerFile (
		.clk(clk),
		.rst(rst),
		.stepPipe(stepPipe),
		.writeBack(writeBack),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.mgmtIndex(mgmtIndex),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.mgmtData(mgmtData)
	);

	managementPort u_managementPort (
		.mgmtReq(mgmtReq),
		.fetchPc(fetchPc),
		.lastInstruction(fetchOut.instruction),
		.mgmtData(mgmtData),
		.readData(mgmtReadData),
		.stepWrite(stepWrite),
		.setWrite(setWrite),
		.mgmtIndex(mgmtIndex)
	);

endmodule

`default_nettype wire

// File: tests/coreChecker.sv
`timescale 1ns/10ps
`default_nettype none

module coreChecker import corePkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire imemReq_t imemReq,
	input wire imemRsp_t imemRsp,
	input wire mgmtReq_t mgmtReq,
	input wire word_t mgmtReadData,
	input wire logic probeState,
	input wire word_t probeProgramCounter,
	input wire logic checkRead,
	input wire logic checkIdle,
	input wire logic checkProbe,
	input wire word_t expectData,
	output int errorCount,
	output int checkCount,
	output int fetchTotal
);

	int testErrors;
	int testChecks;

	initial begin
		errorCount = 0;
		checkCount = 0;
		fetchTotal = 0;
		testErrors = 0;
		testChecks = 0;
	end

	// Fetches the core takes, counted on the accepting edge
	always @(posedge clk) begin
		if (!rst && imemReq.enable && !imemRsp.busy) begin
			fetchTotal++;
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst && checkRead) begin
			checkCount++;
			testChecks++;
			if (mgmtReadData !== expectData) begin
				$display("ERROR %0t: mgmtReadData (address %h) expected %h actual %h",
					$time, mgmtReq.address, expectData, mgmtReadData);
				errorCount++;
				testErrors++;
			end
		end
		if (!rst && checkIdle) begin
			checkCount++;
			testChecks++;
			if (probeState !== 1'b0) begin
				$display("ERROR %0t: probeState expected 0 actual %b", $time, probeState);
				errorCount++;
				testErrors++;
			end
			if (imemReq.enable !== 1'b0) begin
				$display("ERROR %0t: imemReq.enable expected 0 actual %b", $time, imemReq.enable);
				errorCount++;
				testErrors++;
			end
		end
		if (!rst && checkProbe) begin
			checkCount++;
			testChecks++;
			if (probeProgramCounter !== expectData) begin
				$display("ERROR %0t: probeProgramCounter expected %h actual %h",
					$time, expectData, probeProgramCounter);
				errorCount++;
				testErrors++;
			end
		end
	end

	task automatic reportTest(input string name);
		if (testErrors == 0) begin
			$display("Test %s: passed, %0d checks", name, testChecks);
		end else begin
			$display("Test %s: failed, %0d errors in %0d checks", name, testErrors, testChecks);
		end
		testErrors = 0;
		testChecks = 0;
	endtask

endmodule

`default_nettype wire

// File: tests/coreTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module coreTb import corePkg::*; ();

	localparam int ROM_DEPTH = 128;
	localparam int RESET_CYCLES = 16;
	localparam int RUN_CYCLES = 60;
	localparam int STEP_COUNT = 6;
	localparam int LATE_RUN_CYCLES = 20;
	localparam int TESTED_INSTRUCTIONS = RUN_CYCLES + STEP_COUNT + LATE_RUN_CYCLES + 10;
	localparam mgmtAddr_t PC_ADDR = {`MGMT_REGION_SYSTEM, `MGMT_SYS_PC, `MGMT_PC_SET};
	localparam mgmtAddr_t STEP_ADDR = {`MGMT_REGION_SYSTEM, `MGMT_SYS_PC, `MGMT_PC_STEP};
	localparam mgmtAddr_t INSTR_ADDR = {`MGMT_REGION_SYSTEM, `MGMT_SYS_INSTR, 4'h0};

	logic clk;
	logic rst;
	logic busy;
	logic checkRead;
	logic checkIdle;
	logic checkProbe;
	word_t expectData;
	imemReq_t imemReq;
	imemRsp_t imemRsp;
	mgmtReq_t mgmtReq;
	word_t mgmtReadData;
	logic probeState;
	word_t probeProgramCounter;
	int errorCount;
	int checkCount;
	int fetchTotal;
	int fetchStart;
	int fetchCount;
	integer seed = 32'h1bb0_2c36;
	word_t expectPc;
	word_t rom [ROM_DEPTH];
	word_t modelRegs [32];
	logic written [32];

	rv32Core u_dut (
		.clk(clk),
		.rst(rst),
		.imemRsp(imemRsp),
		.mgmtReq(mgmtReq),
		.imemReq(imemReq),
		.mgmtReadData(mgmtReadData),
		.probeState(probeState),
		.probeProgramCounter(probeProgramCounter)
	);

	coreChecker u_checker (
		.clk(clk),
		.rst(rst),
		.imemReq(imemReq),
		.imemRsp(imemRsp),
		.mgmtReq(mgmtReq),
		.mgmtReadData(mgmtReadData),
		.probeState(probeState),
		.probeProgramCounter(probeProgramCounter),
		.checkRead(checkRead),
		.checkIdle(checkIdle),
		.checkProbe(checkProbe),
		.expectData(expectData),
		.errorCount(errorCount),
		.checkCount(checkCount),
		.fetchTotal(fetchTotal)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Instruction ROM answers in the same cycle
	assign imemRsp = {rom[imemReq.address[8:2]], busy};

	always @(posedge clk) begin
		#1 busy = ($unsigned($random(seed)) % 4) == 0;
	end

	function automatic word_t laneMask(input byteSel_t sel);
		return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	endfunction

	function automatic mgmtAddr_t regAddress(input regIndex_t index);
		return {`MGMT_REGION_REGISTERS, 7'd0, index, 2'b00};
	endfunction

	// Mostly the last destination, so dependencies land back to back
	function automatic regIndex_t pickSource(input regIndex_t recent);
		regIndex_t index;
		word_t rnd;
		index = recent;
		rnd = $random(seed);
		if (rnd[8]) begin
			index = rnd[4:0];
			while (!written[index]) begin
				rnd = $random(seed);
				index = rnd[4:0];
			end
		end
		return index;
	endfunction

	task automatic generateProgram;
		regIndex_t rd;
		regIndex_t lastRd;
		logic [2:0] funct3;
		word_t bits;
		int kind;
		lastRd = '0;
		for (int i = 0; i < 32; i++) begin
			written[i] = (i == 0);
		end
		for (int i = 0; i < ROM_DEPTH; i++) begin
			kind = $unsigned($random(seed)) % 11;
			bits = $random(seed);
			rd = bits[24:20];
			case (kind % 4)
				0: funct3 = 3'b000;
				1: funct3 = 3'b100;
				2: funct3 = 3'b110;
				default: funct3 = 3'b111;
			endcase
			if (kind < 4) begin
				rom[i] = {bits[11:0], pickSource(lastRd), funct3, rd, `OPCODE_OPIMM};
			end else if (kind < 8) begin
				rom[i] = {7'b0000000, pickSource(lastRd), pickSource(lastRd), funct3, rd,
					`OPCODE_OP};
			end else if (kind == 8) begin
				rom[i] = {7'b0100000, pickSource(lastRd), pickSource(lastRd), 3'b000, rd,
					`OPCODE_OP};
			end else if (kind == 9) begin
				rom[i] = {bits[19:0], rd, `OPCODE_LUI};
			end else begin
				// SLTI is outside the subset and writes nothing
				rom[i] = {bits[11:0], pickSource(lastRd), 3'b010, rd, `OPCODE_OPIMM};
			end
			if (kind < 10) begin
				written[rd] = 1'b1;
				lastRd = rd;
			end
		end
	endtask

	// Reference model of the subset, updates modelRegs in place
	function automatic void runReference(input word_t startPc, input int count);
		word_t instr;
		word_t a;
		word_t b;
		word_t result;
		logic writes;
		for (int n = 0; n < count; n++) begin
			instr = rom[(startPc >> 2) + n];
			a = modelRegs[instr[19:15]];
			if (instr[6:0] == `OPCODE_OP) begin
				b = modelRegs[instr[24:20]];
			end else begin
				b = {{20{instr[31]}}, instr[31:20]};
			end
			writes = (instr[6:0] == `OPCODE_OP) || (instr[6:0] == `OPCODE_OPIMM);
			result = '0;
			case (instr[14:12])
				3'b000: result = (instr[6:0] == `OPCODE_OP && instr[30]) ? a - b : a + b;
				3'b100: result = a ^ b;
				3'b110: result = a | b;
				3'b111: result = a & b;
				default: writes = 1'b0;
			endcase
			if (instr[6:0] == `OPCODE_LUI) begin
				writes = 1'b1;
				result = {instr[31:12], 12'h000};
			end
			if (writes && instr[11:7] != 5'd0) begin
				modelRegs[instr[11:7]] = result;
			end
		end
	endfunction

	task automatic writeMgmt(input mgmtAddr_t address, input word_t data);
		@(posedge clk);
		#1;
		mgmtReq.writeEnable = 1'b1;
		mgmtReq.address = address;
		mgmtReq.writeData = data;
		@(posedge clk);
		#1;
		mgmtReq.writeEnable = 1'b0;
	endtask

	task automatic checkReadback(
		input mgmtAddr_t address,
		input byteSel_t sel,
		input word_t expected
	);
		@(posedge clk);
		#1;
		mgmtReq.address = address;
		mgmtReq.byteSelect = sel;
		expectData = expected;
		checkRead = 1'b1;
		@(posedge clk);
		#1;
		checkRead = 1'b0;
	endtask

	task automatic checkExecutedPc(input word_t expected);
		@(posedge clk);
		#1;
		expectData = expected;
		checkProbe = 1'b1;
		@(posedge clk);
		#1;
		checkProbe = 1'b0;
	endtask

	task automatic waitHalt;
		@(posedge clk);
		#1;
		while (probeState) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic stepOnce;
		writeMgmt(STEP_ADDR, '0);
		while (!probeState) begin
			@(posedge clk);
			#1;
		end
		waitHalt();
	endtask

	task automatic checkRegisters;
		for (int i = 0; i < 32; i++) begin
			checkReadback(regAddress(i[4:0]), 4'hf, modelRegs[i]);
		end
	endtask

	initial begin
		rst = 1'b1;
		busy = 1'b0;
		checkRead = 1'b0;
		checkIdle = 1'b0;
		checkProbe = 1'b0;
		expectData = '0;
		mgmtReq = '0;
		fetchStart = 0;
		fetchCount = 0;
		modelRegs[0] = '0;
		generateProgram();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		checkIdle = 1'b1;
		@(posedge clk);
		#1;
		checkIdle = 1'b0;
		checkReadback(PC_ADDR, 4'hf, `RESET_PC);
		u_checker.reportTest("reset state");

		writeMgmt(PC_ADDR, 32'h8642_1357);
		for (int sel = 0; sel < 16; sel++) begin
			checkReadback(PC_ADDR, sel[3:0], 32'h8642_1357 & laneMask(sel[3:0]));
		end
		checkReadback(16'hc000, 4'hf, 32'hffff_ffff);
		writeMgmt(PC_ADDR, `RESET_PC);
		stepOnce();
		runReference(`RESET_PC, 1);
		expectPc = `RESET_PC + `PC_STEP;
		checkReadback(INSTR_ADDR, 4'hf, rom[`RESET_PC >> 2]);
		checkReadback(PC_ADDR, 4'hf, expectPc);
		u_checker.reportTest("management readback");

		writeMgmt(PC_ADDR, `RESET_PC);
		fetchStart = fetchTotal;
		mgmtReq.run = 1'b1;
		repeat (RUN_CYCLES) @(posedge clk);
		#1;
		mgmtReq.run = 1'b0;
		waitHalt();
		fetchCount = fetchTotal - fetchStart;
		runReference(`RESET_PC, fetchCount);
		expectPc = `RESET_PC + fetchCount * `PC_STEP;
		checkReadback(PC_ADDR, 4'hf, expectPc);
		checkExecutedPc(expectPc - `PC_STEP);
		checkRegisters();
		u_checker.reportTest("free run");

		for (int n = 0; n < STEP_COUNT; n++) begin
			stepOnce();
		end
		runReference(expectPc, STEP_COUNT);
		expectPc = expectPc + STEP_COUNT * `PC_STEP;
		checkReadback(PC_ADDR, 4'hf, expectPc);
		checkExecutedPc(expectPc - `PC_STEP);
		checkRegisters();
		u_checker.reportTest("single step");

		// Host access is locked out while running
		fetchStart = fetchTotal;
		mgmtReq.run = 1'b1;
		checkReadback(PC_ADDR, 4'hf, laneMask(4'hf));
		checkReadback(INSTR_ADDR, 4'b0110, laneMask(4'b0110));
		checkReadback(regAddress(5'd5), 4'b1001, laneMask(4'b1001));
		writeMgmt(PC_ADDR, 32'h0000_0f00);
		repeat (LATE_RUN_CYCLES) @(posedge clk);
		#1;
		mgmtReq.run = 1'b0;
		waitHalt();
		fetchCount = fetchTotal - fetchStart;
		runReference(expectPc, fetchCount);
		expectPc = expectPc + fetchCount * `PC_STEP;
		checkReadback(PC_ADDR, 4'hf, expectPc);
		checkExecutedPc(expectPc - `PC_STEP);
		u_checker.reportTest("access while running");

		$display("Tests done: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (RESET_CYCLES + 200 * TESTED_INSTRUCTIONS) @(posedge clk);
		$display("Timeout: the core did not finish the tests within %0d cycles",
			RESET_CYCLES + 200 * TESTED_INSTRUCTIONS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/corePkg.sv
hdl/runControl.sv
hdl/programCounter.sv
hdl/fetchStage.sv
hdl/executeStage.sv
hdl/registerFile.sv
hdl/managementPort.sv
hdl/rv32Core.sv
tests/coreChecker.sv
tests/coreTb.sv
